/* bench/tb_prtcl_chkr_csr.sv */
`default_nettype none
`timescale 1ns/1ps

`include "prtcl_chkr_macros.svh"

module tb_prtcl_chkr_csr;

   import prtcl_chkr_pkg::*;

   // ******************************
   // Table and constants
   // ******************************

   typedef enum logic [1:0] {
      op_write,
      op_read,
      op_pulse,
      op_wait
   } op_t;

   // One table row, data is write data or the causes to pulse
   typedef struct packed {
      op_t                          op;
      logic [`PRTCL_CSR_ADDR_W-1:0] addr;
      csr_access_type_t             wtype;
      logic [63:0]                  data;
      logic [63:0]                  expected;
   } step_t;

   // Cause bits, malformed_tlp is bit 9 and tx_mwr_insufficient_data bit 0
   localparam logic [63:0] cause_malformed     = 64'h200;
   localparam logic [63:0] cause_mmio_timeout  = 64'h010;
   localparam logic [63:0] cause_tx_mwr_insuff = 64'h001;

   // Limits in clk_csr edges and in status reads
   localparam int ack_timeout = 50;
   localparam int poll_limit  = 40;

   logic                   clk;
   logic                   clk_csr;
   logic                   rst_n;
   t_prtcl_chkr_err_vector error_vector;
   logic                   req;
   t_csr_req               req_data;
   logic                   ack;
   t_csr_rsp               rsp;

   step_t       steps[$];
   string       step_names[$];
   // Expected scratch contents
   logic [63:0] scratch_model;
   integer      seed;

   prtcl_chkr_csr i_dut (
      .clk          (clk),
      .clk_csr      (clk_csr),
      .rst_n        (rst_n),
      .error_vector (error_vector),
      .req          (req),
      .req_data     (req_data),
      .ack          (ack),
      .rsp          (rsp)
   );

   // Checker clock 20 ns
   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Register clock 30 ns, unrelated phase
   initial begin
      clk_csr = 1'b0;
      forever #15 clk_csr = ~clk_csr;
   end

   // ******************************
   // Helpers
   // ******************************

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (actual !== expected) begin
         $display("ERR %s expected %h actual %h", name, expected, actual);
         $display("Regression failed");
         $fatal(1);
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout while waiting for %s", what);
      $display("Regression failed");
      $fatal(1);
   endtask

   function automatic logic [63:0] random_word();
      random_word = {$random(seed), $random(seed)};
   endfunction

   // One four-phase transfer, ack must rise on the third sampling edge
   task automatic host_access(input string name, input logic is_write,
                              input csr_access_type_t wtype,
                              input logic [`PRTCL_CSR_ADDR_W-1:0] addr,
                              input logic [63:0] wdata, output logic [63:0] rdata);
      int edges;
      @(posedge clk_csr);
      #2;
      req_data.write      = is_write;
      req_data.write_type = wtype;
      req_data.addr       = addr;
      req_data.wdata      = wdata;
      req = 1'b1;
      // Phase 1 to 2, count edges until ack shows
      edges = 0;
      do begin
         @(posedge clk_csr);
         edges++;
         #1;
      end while (!ack && edges < ack_timeout);
      if (!ack) report_timeout({"ack to rise in ", name});
      check_value({name, "_ack_lat"}, 64'd3, 64'(edges));
      rdata = rsp.rdata;
      #1;
      req = 1'b0;
      // Phase 3 to 4
      edges = 0;
      do begin
         @(posedge clk_csr);
         edges++;
         #1;
      end while (ack && edges < ack_timeout);
      if (ack) report_timeout({"ack to fall in ", name});
   endtask

   task automatic host_write(input string name, input csr_access_type_t wtype,
                             input logic [`PRTCL_CSR_ADDR_W-1:0] addr,
                             input logic [63:0] wdata);
      logic [63:0] rdata;
      host_access(name, 1'b1, wtype, addr, wdata, rdata);
      // Writes answer with zero data
      check_value({name, "_rsp"}, 64'h0, rdata);
   endtask

   task automatic host_read(input string name, input logic [`PRTCL_CSR_ADDR_W-1:0] addr,
                            output logic [63:0] rdata);
      host_access(name, 1'b0, FULL64, addr, 64'h0, rdata);
   endtask

   // Causes high for exactly one clk cycle
   task automatic pulse_errors(input logic [9:0] bits);
      @(posedge clk);
      #2;
      error_vector = t_prtcl_chkr_err_vector'(bits);
      @(posedge clk);
      #2;
      error_vector = '0;
   endtask

   // Crossing latency is not fixed, so keep reading status
   task automatic wait_status(input string name, input logic [63:0] expected);
      logic [63:0] value;
      int          polls;
      polls = 0;
      do begin
         host_read(name, `PRTCL_ERR_STATUS_OFS, value);
         polls++;
      end while (value !== expected && polls < poll_limit);
      if (value !== expected) report_timeout({"error status in ", name});
   endtask

   // Byte-enable rule of the write types
   task automatic update_scratch_model(input csr_access_type_t wtype, input logic [63:0] data);
      case (wtype)
         FULL64:  scratch_model = data;
         UPPER32: scratch_model[63:32] = data[63:32];
         LOWER32: scratch_model[31:0] = data[31:0];
         default: scratch_model = scratch_model;
      endcase
   endtask

   task automatic apply_step(input string name, input step_t s);
      logic [63:0] rd;
      logic [63:0] exp_val;
      case (s.op)
         op_write: begin
            host_write(name, s.wtype, s.addr, s.data);
            if (s.addr == `PRTCL_SCRATCH_OFS) update_scratch_model(s.wtype, s.data);
         end
         op_read: begin
            host_read(name, s.addr, rd);
            // Scratch reads are predicted from the model
            exp_val = (s.addr == `PRTCL_SCRATCH_OFS) ? scratch_model : s.expected;
            check_value(name, exp_val, rd);
         end
         op_pulse: pulse_errors(s.data[9:0]);
         op_wait:  wait_status(name, s.expected);
      endcase
   endtask

   task automatic add_step(input string name, input op_t op,
                           input logic [`PRTCL_CSR_ADDR_W-1:0] addr,
                           input csr_access_type_t wtype, input logic [63:0] data,
                           input logic [63:0] expected);
      step_t s;
      s.op       = op;
      s.addr     = addr;
      s.wtype    = wtype;
      s.data     = data;
      s.expected = expected;
      steps.push_back(s);
      step_names.push_back(name);
   endtask

   // ******************************
   // Stimulus table
   // ******************************

   task automatic build_table();
      // Reset values
      add_step("rd_status_rst", op_read, `PRTCL_ERR_STATUS_OFS, FULL64, 64'h0, 64'h0);
      add_step("rd_first_rst", op_read, `PRTCL_FIRST_ERR_OFS, FULL64, 64'h0, 64'h0);
      add_step("rd_scr_rst", op_read, `PRTCL_SCRATCH_OFS, FULL64, 64'h0, 64'h0);
      // Scratch byte enables
      add_step("wr_scr_full", op_write, `PRTCL_SCRATCH_OFS, FULL64, random_word(), 64'h0);
      add_step("rd_scr_full", op_read, `PRTCL_SCRATCH_OFS, FULL64, 64'h0, 64'h0);
      add_step("wr_scr_upper", op_write, `PRTCL_SCRATCH_OFS, UPPER32, random_word(), 64'h0);
      add_step("rd_scr_upper", op_read, `PRTCL_SCRATCH_OFS, FULL64, 64'h0, 64'h0);
      add_step("wr_scr_lower", op_write, `PRTCL_SCRATCH_OFS, LOWER32, random_word(), 64'h0);
      add_step("rd_scr_lower", op_read, `PRTCL_SCRATCH_OFS, FULL64, 64'h0, 64'h0);
      // First cause, then a second one that must not move first_err
      add_step("pulse_malformed", op_pulse, 8'h00, FULL64, cause_malformed, 64'h0);
      add_step("wait_malformed", op_wait, 8'h00, FULL64, 64'h0, cause_malformed);
      add_step("rd_first_load", op_read, `PRTCL_FIRST_ERR_OFS, FULL64, 64'h0, cause_malformed);
      add_step("pulse_timeout", op_pulse, 8'h00, FULL64, cause_mmio_timeout, 64'h0);
      add_step("wait_both", op_wait, 8'h00, FULL64, 64'h0,
               cause_malformed | cause_mmio_timeout);
      add_step("rd_first_keep", op_read, `PRTCL_FIRST_ERR_OFS, FULL64, 64'h0, cause_malformed);
      // Write one to clear
      add_step("clr_malformed", op_write, `PRTCL_ERR_STATUS_OFS, FULL64, cause_malformed, 64'h0);
      add_step("rd_status_part", op_read, `PRTCL_ERR_STATUS_OFS, FULL64, 64'h0,
               cause_mmio_timeout);
      add_step("rd_first_frozen", op_read, `PRTCL_FIRST_ERR_OFS, FULL64, 64'h0, cause_malformed);
      // Upper half write leaves the cause bits alone
      add_step("clr_upper_only", op_write, `PRTCL_ERR_STATUS_OFS, UPPER32, {64{1'b1}}, 64'h0);
      add_step("rd_status_upper", op_read, `PRTCL_ERR_STATUS_OFS, FULL64, 64'h0,
               cause_mmio_timeout);
      add_step("clr_timeout", op_write, `PRTCL_ERR_STATUS_OFS, LOWER32, cause_mmio_timeout,
               64'h0);
      add_step("rd_status_clr", op_read, `PRTCL_ERR_STATUS_OFS, FULL64, 64'h0, 64'h0);
      add_step("rd_first_clr", op_read, `PRTCL_FIRST_ERR_OFS, FULL64, 64'h0, 64'h0);
      // New first error after the log went empty
      add_step("pulse_tx_mwr", op_pulse, 8'h00, FULL64, cause_tx_mwr_insuff, 64'h0);
      add_step("wait_tx_mwr", op_wait, 8'h00, FULL64, 64'h0, cause_tx_mwr_insuff);
      add_step("rd_first_new", op_read, `PRTCL_FIRST_ERR_OFS, FULL64, 64'h0,
               cause_tx_mwr_insuff);
      // Unmapped space and the read-only first_err
      add_step("rd_unmap_18", op_read, 8'h18, FULL64, 64'h0, 64'h0);
      add_step("rd_unmap_04", op_read, 8'h04, FULL64, 64'h0, 64'h0);
      add_step("wr_unmap_20", op_write, 8'h20, FULL64, random_word(), 64'h0);
      add_step("wr_first_ro", op_write, `PRTCL_FIRST_ERR_OFS, FULL64, {64{1'b1}}, 64'h0);
      add_step("rd_first_ro", op_read, `PRTCL_FIRST_ERR_OFS, FULL64, 64'h0,
               cause_tx_mwr_insuff);
      add_step("rd_scr_after", op_read, `PRTCL_SCRATCH_OFS, FULL64, 64'h0, 64'h0);
      add_step("rd_unmap_20", op_read, 8'h20, FULL64, 64'h0, 64'h0);
      add_step("rd_status_end", op_read, `PRTCL_ERR_STATUS_OFS, FULL64, 64'h0,
               cause_tx_mwr_insuff);
   endtask

   // ******************************
   // Main sequence
   // ******************************

   initial begin
      rst_n         = 1'b0;
      req           = 1'b0;
      req_data      = '0;
      error_vector  = '0;
      scratch_model = 64'h0;
      seed          = 32'h9ce7;
      build_table();
      repeat (4) @(posedge clk);
      #2;
      rst_n = 1'b1;
      // Nothing requested yet
      check_value("ack_idle", 64'h0, {63'h0, ack});
      for (int i = 0; i < steps.size(); i++) begin
         apply_step(step_names[i], steps[i]);
      end
      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire

/* files.f */
+incdir+verilog
verilog/prtcl_chkr_pkg.sv
verilog/csr_req_rx.sv
verilog/err_stretch.sv
verilog/err_log.sv
verilog/csr_regs.sv
verilog/csr_rsp_tx.sv
verilog/prtcl_chkr_csr.sv
bench/tb_prtcl_chkr_csr.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 \
   --timescale 1ns/1ps \
   --top-module tb_prtcl_chkr_csr \
   -f files.f \
   -o tb_prtcl_chkr_csr &&
./obj_dir/tb_prtcl_chkr_csr ||
{ echo "Build or simulation failed"; exit 1; }

/* verilog/csr_regs.sv */
`default_nettype none
`timescale 1ns/1ps

`include "prtcl_chkr_macros.svh"

module csr_regs (
   input  logic                                  clk_csr,
   input  logic                                  rst_n,
   input  logic                                  cmd_valid,
   input  prtcl_chkr_pkg::t_csr_req               cmd,
   input  prtcl_chkr_pkg::t_prtcl_chkr_err_vector err_status,
   input  prtcl_chkr_pkg::t_prtcl_chkr_err_vector first_err,
   output logic                                  result_valid,
   output prtcl_chkr_pkg::t_csr_rsp               result,
   output logic                                  clr_valid,
   output prtcl_chkr_pkg::t_prtcl_chkr_err_vector clr_mask
);

   import prtcl_chkr_pkg::*;

   localparam int err_w = $bits(t_prtcl_chkr_err_vector);

   logic [7:0]  byte_en;
   logic [63:0] wmask;
   logic [63:0] wdata_masked;
   logic [63:0] rd_data;
   logic [63:0] scratch;
   logic        hit_status;
   logic        hit_first;
   logic        hit_scratch;

   // ******************************
   // Decode
   // ******************************

   assign hit_status  = (cmd.addr == `PRTCL_ERR_STATUS_OFS);
   assign hit_first   = (cmd.addr == `PRTCL_FIRST_ERR_OFS);
   assign hit_scratch = (cmd.addr == `PRTCL_SCRATCH_OFS);

   // Write type to byte enables, then to a bit mask
   always_comb begin
      case (cmd.write_type)
         FULL64:  byte_en = 8'hff;
         UPPER32: byte_en = 8'hf0;
         LOWER32: byte_en = 8'h0f;
         default: byte_en = 8'h00;
      endcase
      for (int b = 0; b < 8; b++) begin
         wmask[b*8 +: 8] = {8{byte_en[b]}};
      end
   end

   assign wdata_masked = cmd.wdata & wmask;

   // Read mux, causes zero-extended, unmapped reads as zero
   always_comb begin
      rd_data = 64'h0;
      if (hit_status) begin
         rd_data = {{(64-err_w){1'b0}}, err_status};
      end else if (hit_first) begin
         rd_data = {{(64-err_w){1'b0}}, first_err};
      end else if (hit_scratch) begin
         rd_data = scratch;
      end
   end

   // ******************************
   // Access
   // ******************************

   always_ff @(posedge clk_csr or negedge rst_n) begin
      if (!rst_n) begin
         result_valid <= 1'b0;
         clr_valid    <= 1'b0;
         scratch      <= 64'h0;
      end else begin
         // Every command gets a response
         result_valid <= cmd_valid;
         clr_valid    <= cmd_valid && cmd.write && hit_status;
         // Only the enabled bytes of scratch change
         if (cmd_valid && cmd.write && hit_scratch) begin
            scratch <= (scratch & ~wmask) | wdata_masked;
         end
      end
   end

   // Response data and clear mask, qualified by their valids
   always_ff @(posedge clk_csr) begin
      if (cmd_valid) begin
         result.rdata <= cmd.write ? 64'h0 : rd_data;
         clr_mask     <= wdata_masked[err_w-1:0];
      end
   end

endmodule

`default_nettype wire

/* verilog/csr_req_rx.sv */
`default_nettype none
`timescale 1ns/1ps

module csr_req_rx (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    req,
   input  prtcl_chkr_pkg::t_csr_req req_data,
   input  logic                    busy,
   output logic                    cmd_valid,
   output prtcl_chkr_pkg::t_csr_req cmd
);

   // Idle, command just issued, waiting for the handshake to finish
   typedef enum logic [1:0] {
      st_idle,
      st_issued,
      st_wait_rel
   } state_t;

   state_t state;
   logic   take;

   // New request accepted when armed and the output side is free
   // In wait_rel req has already been seen low, so a high req is a fresh one
   assign take = req && !busy && (state == st_idle || state == st_wait_rel);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= st_idle;
         cmd_valid <= 1'b0;
      end else begin
         // One pulse per accepted request
         cmd_valid <= take;
         case (state)
            st_idle: begin
               if (take) state <= st_issued;
            end
            st_issued: begin
               // Host drops req only after ack, so this marks the release
               if (!req) state <= st_wait_rel;
            end
            st_wait_rel: begin
               if (take) begin
                  state <= st_issued;
               end else if (!busy) begin
                  state <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // Request payload, latched with the accept
   always_ff @(posedge clk) begin
      if (take) cmd <= req_data;
   end

endmodule

`default_nettype wire

/* verilog/csr_rsp_tx.sv */
`default_nettype none
`timescale 1ns/1ps

module csr_rsp_tx (
   input  logic                    clk_csr,
   input  logic                    rst_n,
   input  logic                    result_valid,
   input  prtcl_chkr_pkg::t_csr_rsp result,
   input  logic                    req,
   output logic                    ack,
   output prtcl_chkr_pkg::t_csr_rsp rsp,
   output logic                    busy
);

   // ******************************
   // Four-phase ack
   // ******************************

   // Rise one cycle after the result
   // Fall on the first edge that sees req low
   always_ff @(posedge clk_csr or negedge rst_n) begin
      if (!rst_n) begin
         ack <= 1'b0;
      end else if (result_valid) begin
         ack <= 1'b1;
      end else if (!req) begin
         ack <= 1'b0;
      end
   end

   // Response held for the whole ack high phase
   always_ff @(posedge clk_csr) begin
      if (result_valid) begin
         rsp <= result;
      end
   end

   // Result in flight or ack still high
   // Input side stays blocked until the handshake has closed
   assign busy = result_valid | ack;

endmodule

`default_nettype wire

/* verilog/err_log.sv */
`default_nettype none
`timescale 1ns/1ps

`include "prtcl_chkr_macros.svh"

module err_log (
   input  logic                                  clk_csr,
   input  logic                                  rst_n,
   input  prtcl_chkr_pkg::t_prtcl_chkr_err_vector error_vector_or,
   input  logic                                  clr_valid,
   input  prtcl_chkr_pkg::t_prtcl_chkr_err_vector clr_mask,
   output prtcl_chkr_pkg::t_prtcl_chkr_err_vector err_status,
   output prtcl_chkr_pkg::t_prtcl_chkr_err_vector first_err
);

   import prtcl_chkr_pkg::*;

   localparam int stages = `PRTCL_SYNC_STAGES;

   // ******************************
   // Clock domain crossing
   // ******************************

   // Plain flop chain per bit
   // Each bit is a stretched level, so bits need no mutual alignment
   t_prtcl_chkr_err_vector sync_q [stages];
   t_prtcl_chkr_err_vector err_sync;

   always_ff @(posedge clk_csr or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < stages; i++) begin
            sync_q[i] <= '0;
         end
      end else begin
         sync_q[0] <= error_vector_or;
         for (int i = 1; i < stages; i++) begin
            sync_q[i] <= sync_q[i-1];
         end
      end
   end

   assign err_sync = sync_q[stages-1];

   // ******************************
   // Sticky status
   // ******************************

   // Status after the write-one-to-clear, before new causes
   t_prtcl_chkr_err_vector status_kept;
   t_prtcl_chkr_err_vector status_next;

   always_comb begin
      status_kept = err_status;
      if (clr_valid) begin
         status_kept = err_status & ~clr_mask;
      end
      // A cause in the same cycle as its clear stays set
      status_next = status_kept | err_sync;
   end

   always_ff @(posedge clk_csr or negedge rst_n) begin
      if (!rst_n) begin
         err_status <= '0;
      end else begin
         err_status <= status_next;
      end
   end

   // ******************************
   // First error
   // ******************************

   // Tracks the incoming causes only while nothing is held in status
   // Status nonzero freezes it
   // A clear down to zero with no cause loads zero
   // A clear down to zero with a cause loads the new first error
   always_ff @(posedge clk_csr or negedge rst_n) begin
      if (!rst_n) begin
         first_err <= '0;
      end else if (status_kept == '0) begin
         first_err <= err_sync;
      end
   end

endmodule

`default_nettype wire

/* verilog/err_stretch.sv */
`default_nettype none
`timescale 1ns/1ps

`include "prtcl_chkr_macros.svh"

module err_stretch (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  prtcl_chkr_pkg::t_prtcl_chkr_err_vector error_vector,
   output prtcl_chkr_pkg::t_prtcl_chkr_err_vector error_vector_or
);

   import prtcl_chkr_pkg::*;

   localparam int depth = `PRTCL_ERR_STRETCH;

   // Entry 0 is the registered input, older samples further up
   t_prtcl_chkr_err_vector err_hist [depth];
   t_prtcl_chkr_err_vector hist_or;

   // OR of the whole window
   always_comb begin
      hist_or = '0;
      for (int i = 0; i < depth; i++) begin
         hist_or = hist_or | err_hist[i];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < depth; i++) begin
            err_hist[i] <= '0;
         end
         error_vector_or <= '0;
      end else begin
         err_hist[0] <= error_vector;
         for (int i = 1; i < depth; i++) begin
            err_hist[i] <= err_hist[i-1];
         end
         // Output stays high for the full window, wide enough for clk_csr
         error_vector_or <= hist_or;
      end
   end

endmodule

`default_nettype wire

/* verilog/prtcl_chkr_csr.sv */
`default_nettype none
`timescale 1ns/1ps

module prtcl_chkr_csr (
   input  logic                                  clk,
   input  logic                                  clk_csr,
   input  logic                                  rst_n,
   input  prtcl_chkr_pkg::t_prtcl_chkr_err_vector error_vector,
   input  logic                                  req,
   input  prtcl_chkr_pkg::t_csr_req               req_data,
   output logic                                  ack,
   output prtcl_chkr_pkg::t_csr_rsp               rsp
);

   import prtcl_chkr_pkg::*;

   // Host command path
   logic                   cmd_valid;
   t_csr_req               cmd;
   logic                   result_valid;
   t_csr_rsp               result;
   logic                   busy;

   // Error path
   t_prtcl_chkr_err_vector error_vector_or;
   logic                   clr_valid;
   t_prtcl_chkr_err_vector clr_mask;
   t_prtcl_chkr_err_vector err_status;
   t_prtcl_chkr_err_vector first_err;

   // ******************************
   // clk_csr side
   // ******************************

   csr_req_rx i_req_rx (
      .clk       (clk_csr),
      .rst_n     (rst_n),
      .req       (req),
      .req_data  (req_data),
      .busy      (busy),
      .cmd_valid (cmd_valid),
      .cmd       (cmd)
   );

   csr_regs i_regs (
      .clk_csr      (clk_csr),
      .rst_n        (rst_n),
      .cmd_valid    (cmd_valid),
      .cmd          (cmd),
      .err_status   (err_status),
      .first_err    (first_err),
      .result_valid (result_valid),
      .result       (result),
      .clr_valid    (clr_valid),
      .clr_mask     (clr_mask)
   );

   csr_rsp_tx i_rsp_tx (
      .clk_csr      (clk_csr),
      .rst_n        (rst_n),
      .result_valid (result_valid),
      .result       (result),
      .req          (req),
      .ack          (ack),
      .rsp          (rsp),
      .busy         (busy)
   );

   // Sticky log, fed across the clock boundary
   err_log i_log (
      .clk_csr         (clk_csr),
      .rst_n           (rst_n),
      .error_vector_or (error_vector_or),
      .clr_valid       (clr_valid),
      .clr_mask        (clr_mask),
      .err_status      (err_status),
      .first_err       (first_err)
   );

   // ******************************
   // clk side
   // ******************************

   err_stretch i_stretch (
      .clk             (clk),
      .rst_n           (rst_n),
      .error_vector    (error_vector),
      .error_vector_or (error_vector_or)
   );

endmodule

`default_nettype wire

/* verilog/prtcl_chkr_macros.svh */
`ifndef PRTCL_CHKR_MACROS_SVH
`define PRTCL_CHKR_MACROS_SVH

// ******************************
// Register map
// ******************************

// Byte address width of the host channel
`define PRTCL_CSR_ADDR_W 8

// Byte offsets, every other address is unmapped
`define PRTCL_ERR_STATUS_OFS 8'h00
`define PRTCL_FIRST_ERR_OFS  8'h08
`define PRTCL_SCRATCH_OFS    8'h10

// Number of clk samples ORed into the stretched error vector
`define PRTCL_ERR_STRETCH 5

// Flop stages from clk into clk_csr
`define PRTCL_SYNC_STAGES 3

`endif

/* verilog/prtcl_chkr_pkg.sv */
`default_nettype none

`include "prtcl_chkr_macros.svh"

package prtcl_chkr_pkg;

   // ******************************
   // Error causes
   // ******************************

   // One bit per cause, raised by the checker for one clk cycle
   typedef struct packed {
      logic malformed_tlp;
      logic max_payload;
      logic max_read_req_size;
      logic max_tag;
      logic unexp_mmio_rsp;
      logic mmio_timeout;
      logic mmio_data_payload_overrun;
      logic mmio_insufficient_data;
      logic tx_mwr_data_payload_overrun;
      logic tx_mwr_insufficient_data;
   } t_prtcl_chkr_err_vector;

   // ******************************
   // Host channel
   // ******************************

   // Width of a write, reads are always 64 bits
   typedef enum logic [1:0] {
      FULL64,
      UPPER32,
      LOWER32
   } csr_access_type_t;

   // Request, held stable by the host while req is high
   typedef struct packed {
      logic                         write;
      csr_access_type_t             write_type;
      logic [`PRTCL_CSR_ADDR_W-1:0] addr;
      logic [63:0]                  wdata;
   } t_csr_req;

   // Response, valid while ack is high
   typedef struct packed {
      logic [63:0] rdata;
   } t_csr_rsp;

endpackage

`default_nettype wire
